/* rtl/proc_pkg.sv */
// Shared definitions of the five-stage core
// Word-addressed memories, 32-bit instruction words with 5-bit opcodes
// An all-zero word is add r0, r0, r0 and serves as the pipeline bubble
package proc_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;
    localparam int OP_W   = 5;

    localparam logic [OP_W-1:0] OP_RTYPE = 5'b00000;
    localparam logic [OP_W-1:0] OP_J     = 5'b00001;
    localparam logic [OP_W-1:0] OP_BNE   = 5'b00010;
    localparam logic [OP_W-1:0] OP_ADDI  = 5'b00101;
    localparam logic [OP_W-1:0] OP_BLT   = 5'b00110;
    localparam logic [OP_W-1:0] OP_SW    = 5'b00111;
    localparam logic [OP_W-1:0] OP_LW    = 5'b01000;

    localparam logic [OP_W-1:0] ALU_ADD = 5'd0;
    localparam logic [OP_W-1:0] ALU_SUB = 5'd1;
    localparam logic [OP_W-1:0] ALU_AND = 5'd2;
    localparam logic [OP_W-1:0] ALU_OR  = 5'd3;
    localparam logic [OP_W-1:0] ALU_SLL = 5'd4;
    localparam logic [OP_W-1:0] ALU_SRA = 5'd5;

    // One word, three formats
    typedef union packed {
        struct packed {
            logic [OP_W-1:0]   opcode;
            logic [REG_AW-1:0] rd;
            logic [REG_AW-1:0] rs;
            logic [REG_AW-1:0] rt;
            logic [4:0]        shamt;
            logic [OP_W-1:0]   alu_op;
            logic [1:0]        zero;
        } r;
        struct packed {
            logic [OP_W-1:0]   opcode;
            logic [REG_AW-1:0] rd;
            logic [REG_AW-1:0] rs;
            logic [16:0]       imm;     // Signed, sign-extended in decode
        } i;
        struct packed {
            logic [OP_W-1:0]   opcode;
            logic [26:0]       target;  // Absolute word address
        } j;
    } instr_u;

    typedef enum logic [1:0] {
        FWD_REG = 2'd0,  // Value read in decode
        FWD_MEM = 2'd1,  // Result held in X/M
        FWD_WB  = 2'd2   // Data on the retire port
    } fwd_sel_e;

endpackage

/* rtl/reg_file.sv */
// 32 x 32 register file, register 0 reads as zero
// Same-cycle write data is passed through to both reads
`timescale 1ns/1ps
module reg_file (
    input  logic                        clock_i,
    input  logic                        rst_n_i,
    input  logic [proc_pkg::REG_AW-1:0] ra_i,
    input  logic [proc_pkg::REG_AW-1:0] rb_i,
    output logic [proc_pkg::XLEN-1:0]   rdata_a_o,
    output logic [proc_pkg::XLEN-1:0]   rdata_b_o,
    input  logic                        we_i,
    input  logic [proc_pkg::REG_AW-1:0] wa_i,
    input  logic [proc_pkg::XLEN-1:0]   wdata_i
);

    logic [proc_pkg::XLEN-1:0] regs [32];

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && wa_i != '0) begin  // r0 stays zero
            regs[wa_i] <= wdata_i;
        end
    end

    assign rdata_a_o = (ra_i == '0) ? '0 : (we_i && wa_i == ra_i) ? wdata_i : regs[ra_i];
    assign rdata_b_o = (rb_i == '0) ? '0 : (we_i && wa_i == rb_i) ? wdata_i : regs[rb_i];

endmodule

/* rtl/alu.sv */
// Six-operation ALU with compare flags for the branches
// less_than_o is a signed compare of a_i with b_i
`timescale 1ns/1ps
module alu (
    input  logic [proc_pkg::XLEN-1:0] a_i,
    input  logic [proc_pkg::XLEN-1:0] b_i,
    input  logic [proc_pkg::OP_W-1:0] op_i,
    input  logic [4:0]                shamt_i,
    output logic [proc_pkg::XLEN-1:0] result_o,
    output logic                      not_equal_o,
    output logic                      less_than_o
);

    always_comb begin
        case (op_i)
            proc_pkg::ALU_ADD: result_o = a_i + b_i;
            proc_pkg::ALU_SUB: result_o = a_i - b_i;
            proc_pkg::ALU_AND: result_o = a_i & b_i;
            proc_pkg::ALU_OR:  result_o = a_i | b_i;
            proc_pkg::ALU_SLL: result_o = a_i << shamt_i;
            proc_pkg::ALU_SRA: result_o = $signed(a_i) >>> shamt_i;  // Keeps the sign
            default:           result_o = '0;                        // Unused codes
        endcase
    end

    assign not_equal_o = (a_i != b_i);
    assign less_than_o = ($signed(a_i) < $signed(b_i));

endmodule

/* rtl/hazard_unit.sv */
// Bypass selection, load-use stall and flush on redirect
// Only rd/rs/rt fields and opcodes of the four stages are inspected
`timescale 1ns/1ps
module hazard_unit (
    input  proc_pkg::instr_u   d_instr_i,
    input  proc_pkg::instr_u   x_instr_i,
    input  proc_pkg::instr_u   m_instr_i,
    input  proc_pkg::instr_u   w_instr_i,
    input  logic               redirect_i,
    output logic               stall_o,
    output logic               flush_o,
    output proc_pkg::fwd_sel_e fwd_a_o,
    output proc_pkg::fwd_sel_e fwd_b_o,
    output logic               store_fwd_o
);

    logic [proc_pkg::REG_AW-1:0] x_src_b;
    logic [proc_pkg::REG_AW-1:0] d_src_b;
    logic                        d_uses_a;
    logic                        d_uses_b;

    // Instruction writes a nonzero register
    function automatic logic writes_reg(input proc_pkg::instr_u ins);
        writes_reg = (ins.r.opcode == proc_pkg::OP_RTYPE || ins.r.opcode == proc_pkg::OP_ADDI
                      || ins.r.opcode == proc_pkg::OP_LW) && (ins.r.rd != '0);
    endfunction

    // Youngest producer wins
    function automatic proc_pkg::fwd_sel_e pick(input logic [proc_pkg::REG_AW-1:0] src,
                                                input proc_pkg::instr_u m,
                                                input proc_pkg::instr_u w);
        if (writes_reg(m) && m.r.rd == src) begin
            pick = proc_pkg::FWD_MEM;
        end else if (writes_reg(w) && w.r.rd == src) begin
            pick = proc_pkg::FWD_WB;
        end else begin
            pick = proc_pkg::FWD_REG;
        end
    endfunction

    // Operand B is rt for register format, rd otherwise (branch compare, store data)
    assign x_src_b = (x_instr_i.r.opcode == proc_pkg::OP_RTYPE) ? x_instr_i.r.rt : x_instr_i.r.rd;
    assign d_src_b = (d_instr_i.r.opcode == proc_pkg::OP_RTYPE) ? d_instr_i.r.rt : d_instr_i.r.rd;

    assign fwd_a_o = pick(x_instr_i.r.rs, m_instr_i, w_instr_i);
    assign fwd_b_o = pick(x_src_b, m_instr_i, w_instr_i);

    assign d_uses_a = (d_instr_i.r.opcode != proc_pkg::OP_J);
    assign d_uses_b = (d_instr_i.r.opcode == proc_pkg::OP_RTYPE)
                   || (d_instr_i.r.opcode == proc_pkg::OP_BNE)
                   || (d_instr_i.r.opcode == proc_pkg::OP_BLT);  // sw data is fixed up in M

    assign stall_o = (x_instr_i.r.opcode == proc_pkg::OP_LW) && (x_instr_i.r.rd != '0)
                  && ((d_uses_a && d_instr_i.r.rs == x_instr_i.r.rd)
                   || (d_uses_b && d_src_b == x_instr_i.r.rd));

    // Store right behind its data producer, incl. a load
    assign store_fwd_o = (m_instr_i.r.opcode == proc_pkg::OP_SW) && writes_reg(w_instr_i)
                      && (w_instr_i.r.rd == m_instr_i.r.rd);

    assign flush_o = redirect_i;  // Kills F/D and D/X on the next edge

endmodule

/* rtl/fetch_stage.sv */
// Program counter and F/D register
// Redirect takes priority over stall, flush loads a bubble into F/D
`timescale 1ns/1ps
module fetch_stage (
    input  logic                      clock_i,
    input  logic                      rst_n_i,
    input  logic                      stall_i,
    input  logic                      flush_i,
    input  logic                      redirect_i,
    input  logic [proc_pkg::XLEN-1:0] redirect_pc_i,
    input  logic [proc_pkg::XLEN-1:0] q_imem_i,
    output logic [proc_pkg::XLEN-1:0] address_imem_o,
    output logic [proc_pkg::XLEN-1:0] fd_pc_o,
    output proc_pkg::instr_u          fd_instr_o
);

    logic [proc_pkg::XLEN-1:0] pc;

    assign address_imem_o = pc;

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            pc <= '0;
        end else if (redirect_i) begin
            pc <= redirect_pc_i;      // Taken branch or jump
        end else if (!stall_i) begin
            pc <= pc + 1'b1;          // Word addressed
        end
    end

    always_ff @(posedge clock_i) begin
        if (!rst_n_i || flush_i) begin
            fd_instr_o <= '0;         // Bubble
        end else if (!stall_i) begin
            fd_instr_o <= q_imem_i;
        end
    end

    always_ff @(posedge clock_i) begin
        if (!stall_i) begin
            fd_pc_o <= pc;
        end
    end

endmodule

/* rtl/decode_stage.sv */
// Register read addressing, immediate extension and D/X register
// Reads rs/rt for register format, rs/rd for all other formats
`timescale 1ns/1ps
module decode_stage (
    input  logic                        clock_i,
    input  logic                        rst_n_i,
    input  logic                        stall_i,
    input  logic                        flush_i,
    input  logic [proc_pkg::XLEN-1:0]   fd_pc_i,
    input  proc_pkg::instr_u            fd_instr_i,
    output logic [proc_pkg::REG_AW-1:0] ra_o,
    output logic [proc_pkg::REG_AW-1:0] rb_o,
    input  logic [proc_pkg::XLEN-1:0]   rdata_a_i,
    input  logic [proc_pkg::XLEN-1:0]   rdata_b_i,
    output logic [proc_pkg::XLEN-1:0]   dx_pc_o,
    output proc_pkg::instr_u            dx_instr_o,
    output logic [proc_pkg::XLEN-1:0]   dx_a_o,
    output logic [proc_pkg::XLEN-1:0]   dx_b_o,
    output logic [proc_pkg::XLEN-1:0]   dx_imm_o
);

    logic [proc_pkg::XLEN-1:0] imm;

    assign ra_o = fd_instr_i.r.rs;
    assign rb_o = (fd_instr_i.r.opcode == proc_pkg::OP_RTYPE) ? fd_instr_i.r.rt : fd_instr_i.r.rd;
    assign imm  = {{(proc_pkg::XLEN-17){fd_instr_i.i.imm[16]}}, fd_instr_i.i.imm};

    always_ff @(posedge clock_i) begin
        if (!rst_n_i || stall_i || flush_i) begin
            dx_instr_o <= '0;         // Bubble for load-use or redirect
        end else begin
            dx_instr_o <= fd_instr_i;
        end
    end

    always_ff @(posedge clock_i) begin
        dx_pc_o  <= fd_pc_i;
        dx_a_o   <= rdata_a_i;
        dx_b_o   <= rdata_b_i;
        dx_imm_o <= imm;
    end

endmodule

/* rtl/execute_stage.sv */
// Operand bypass muxes, ALU, branch/jump resolution and X/M register
// Branches compare rd (operand B) against rs (operand A)
// Redirect is combinational and resolved in this stage only
`timescale 1ns/1ps
module execute_stage (
    input  logic                      clock_i,
    input  logic                      rst_n_i,
    input  logic [proc_pkg::XLEN-1:0] dx_pc_i,
    input  proc_pkg::instr_u          dx_instr_i,
    input  logic [proc_pkg::XLEN-1:0] dx_a_i,
    input  logic [proc_pkg::XLEN-1:0] dx_b_i,
    input  logic [proc_pkg::XLEN-1:0] dx_imm_i,
    input  proc_pkg::fwd_sel_e        fwd_a_i,
    input  proc_pkg::fwd_sel_e        fwd_b_i,
    input  logic [proc_pkg::XLEN-1:0] m_result_i,
    input  logic [proc_pkg::XLEN-1:0] w_data_i,
    output logic                      redirect_o,
    output logic [proc_pkg::XLEN-1:0] redirect_pc_o,
    output proc_pkg::instr_u          xm_instr_o,
    output logic [proc_pkg::XLEN-1:0] xm_result_o,
    output logic [proc_pkg::XLEN-1:0] xm_store_o
);

    logic [proc_pkg::OP_W-1:0] opcode;
    logic [proc_pkg::XLEN-1:0] a_val;
    logic [proc_pkg::XLEN-1:0] b_val;
    logic [proc_pkg::XLEN-1:0] alu_a;
    logic [proc_pkg::XLEN-1:0] alu_b;
    logic [proc_pkg::OP_W-1:0] alu_op;
    logic [proc_pkg::XLEN-1:0] alu_result;
    logic                      not_equal;
    logic                      less_than;

    function automatic logic [proc_pkg::XLEN-1:0] bypass(input proc_pkg::fwd_sel_e sel,
                                                         input logic [proc_pkg::XLEN-1:0] reg_val,
                                                         input logic [proc_pkg::XLEN-1:0] m_val,
                                                         input logic [proc_pkg::XLEN-1:0] w_val);
        case (sel)
            proc_pkg::FWD_MEM: bypass = m_val;
            proc_pkg::FWD_WB:  bypass = w_val;
            default:           bypass = reg_val;
        endcase
    endfunction

    assign opcode = dx_instr_i.r.opcode;
    assign a_val  = bypass(fwd_a_i, dx_a_i, m_result_i, w_data_i);
    assign b_val  = bypass(fwd_b_i, dx_b_i, m_result_i, w_data_i);

    always_comb begin
        alu_a  = a_val;
        alu_b  = b_val;
        alu_op = proc_pkg::ALU_ADD;
        case (opcode)
            proc_pkg::OP_RTYPE: alu_op = dx_instr_i.r.alu_op;
            proc_pkg::OP_BNE, proc_pkg::OP_BLT: begin
                alu_a  = b_val;             // rd
                alu_b  = a_val;             // rs
                alu_op = proc_pkg::ALU_SUB;
            end
            default: alu_b = dx_imm_i;      // addi and load/store address
        endcase
    end

    alu u_alu (
        .a_i        (alu_a),
        .b_i        (alu_b),
        .op_i       (alu_op),
        .shamt_i    (dx_instr_i.r.shamt),
        .result_o   (alu_result),
        .not_equal_o(not_equal),
        .less_than_o(less_than)
    );

    assign redirect_o = (opcode == proc_pkg::OP_J)
                     || (opcode == proc_pkg::OP_BNE && not_equal)
                     || (opcode == proc_pkg::OP_BLT && less_than);

    assign redirect_pc_o = (opcode == proc_pkg::OP_J)
                         ? {{(proc_pkg::XLEN-27){1'b0}}, dx_instr_i.j.target}
                         : dx_pc_i + 1'b1 + dx_imm_i;

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            xm_instr_o <= '0;
        end else begin
            xm_instr_o <= dx_instr_i;
        end
    end

    always_ff @(posedge clock_i) begin
        xm_result_o <= alu_result;
        xm_store_o  <= b_val;               // Store data, may be patched in M
    end

endmodule

/* rtl/mem_wb_stage.sv */
// Data memory drive, M/W register and writeback select
// Store data comes from writeback when store_fwd_i is set
`timescale 1ns/1ps
module mem_wb_stage (
    input  logic                        clock_i,
    input  logic                        rst_n_i,
    input  proc_pkg::instr_u            xm_instr_i,
    input  logic [proc_pkg::XLEN-1:0]   xm_result_i,
    input  logic [proc_pkg::XLEN-1:0]   xm_store_i,
    input  logic                        store_fwd_i,
    input  logic [proc_pkg::XLEN-1:0]   q_dmem_i,
    output logic [proc_pkg::XLEN-1:0]   address_dmem_o,
    output logic [proc_pkg::XLEN-1:0]   data_dmem_o,
    output logic                        wren_o,
    output proc_pkg::instr_u            w_instr_o,
    output logic                        wb_en_o,
    output logic [proc_pkg::REG_AW-1:0] wb_reg_o,
    output logic [proc_pkg::XLEN-1:0]   wb_data_o
);

    logic [proc_pkg::XLEN-1:0] mw_result;
    logic [proc_pkg::XLEN-1:0] mw_load;
    logic [proc_pkg::OP_W-1:0] w_op;

    assign address_dmem_o = xm_result_i;
    assign data_dmem_o    = store_fwd_i ? wb_data_o : xm_store_i;
    assign wren_o         = (xm_instr_i.r.opcode == proc_pkg::OP_SW);

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            w_instr_o <= '0;
        end else begin
            w_instr_o <= xm_instr_i;
        end
    end

    always_ff @(posedge clock_i) begin
        mw_result <= xm_result_i;
        mw_load   <= q_dmem_i;              // Same-cycle read data
    end

    assign w_op      = w_instr_o.r.opcode;
    assign wb_en_o   = (w_op == proc_pkg::OP_RTYPE || w_op == proc_pkg::OP_ADDI
                        || w_op == proc_pkg::OP_LW) && (w_instr_o.r.rd != '0);
    assign wb_reg_o  = w_instr_o.r.rd;
    assign wb_data_o = (w_op == proc_pkg::OP_LW) ? mw_load : mw_result;

endmodule

/* rtl/processor.sv */
// Five-stage pipelined core, memories stay outside
// Both memories must answer combinationally in the same cycle
// Retire port mirrors the register file write port
`timescale 1ns/1ps
module processor (
    input  logic                        clock_i,
    input  logic                        rst_n_i,
    output logic [proc_pkg::XLEN-1:0]   address_imem_o,
    input  logic [proc_pkg::XLEN-1:0]   q_imem_i,
    output logic [proc_pkg::XLEN-1:0]   address_dmem_o,
    output logic [proc_pkg::XLEN-1:0]   data_dmem_o,
    output logic                        wren_o,
    input  logic [proc_pkg::XLEN-1:0]   q_dmem_i,
    output logic                        wb_en_o,
    output logic [proc_pkg::REG_AW-1:0] wb_reg_o,
    output logic [proc_pkg::XLEN-1:0]   wb_data_o
);

    logic                        stall;
    logic                        flush;
    logic                        redirect;
    logic [proc_pkg::XLEN-1:0]   redirect_pc;
    proc_pkg::fwd_sel_e          fwd_a;
    proc_pkg::fwd_sel_e          fwd_b;
    logic                        store_fwd;
    logic [proc_pkg::XLEN-1:0]   fd_pc;
    proc_pkg::instr_u            fd_instr;
    logic [proc_pkg::REG_AW-1:0] ra;
    logic [proc_pkg::REG_AW-1:0] rb;
    logic [proc_pkg::XLEN-1:0]   rdata_a;
    logic [proc_pkg::XLEN-1:0]   rdata_b;
    logic [proc_pkg::XLEN-1:0]   dx_pc;
    proc_pkg::instr_u            dx_instr;
    logic [proc_pkg::XLEN-1:0]   dx_a;
    logic [proc_pkg::XLEN-1:0]   dx_b;
    logic [proc_pkg::XLEN-1:0]   dx_imm;
    proc_pkg::instr_u            xm_instr;
    logic [proc_pkg::XLEN-1:0]   xm_result;
    logic [proc_pkg::XLEN-1:0]   xm_store;
    proc_pkg::instr_u            w_instr;

    fetch_stage u_fetch (
        .clock_i(clock_i), .rst_n_i(rst_n_i), .stall_i(stall), .flush_i(flush),
        .redirect_i(redirect), .redirect_pc_i(redirect_pc), .q_imem_i(q_imem_i),
        .address_imem_o(address_imem_o), .fd_pc_o(fd_pc), .fd_instr_o(fd_instr)
    );

    decode_stage u_decode (
        .clock_i(clock_i), .rst_n_i(rst_n_i), .stall_i(stall), .flush_i(flush),
        .fd_pc_i(fd_pc), .fd_instr_i(fd_instr), .ra_o(ra), .rb_o(rb),
        .rdata_a_i(rdata_a), .rdata_b_i(rdata_b), .dx_pc_o(dx_pc), .dx_instr_o(dx_instr),
        .dx_a_o(dx_a), .dx_b_o(dx_b), .dx_imm_o(dx_imm)
    );

    execute_stage u_execute (
        .clock_i(clock_i), .rst_n_i(rst_n_i), .dx_pc_i(dx_pc), .dx_instr_i(dx_instr),
        .dx_a_i(dx_a), .dx_b_i(dx_b), .dx_imm_i(dx_imm), .fwd_a_i(fwd_a), .fwd_b_i(fwd_b),
        .m_result_i(xm_result), .w_data_i(wb_data_o), .redirect_o(redirect),
        .redirect_pc_o(redirect_pc), .xm_instr_o(xm_instr), .xm_result_o(xm_result),
        .xm_store_o(xm_store)
    );

    mem_wb_stage u_mem_wb (
        .clock_i(clock_i), .rst_n_i(rst_n_i), .xm_instr_i(xm_instr), .xm_result_i(xm_result),
        .xm_store_i(xm_store), .store_fwd_i(store_fwd), .q_dmem_i(q_dmem_i),
        .address_dmem_o(address_dmem_o), .data_dmem_o(data_dmem_o), .wren_o(wren_o),
        .w_instr_o(w_instr), .wb_en_o(wb_en_o), .wb_reg_o(wb_reg_o), .wb_data_o(wb_data_o)
    );

    hazard_unit u_hazard (
        .d_instr_i(fd_instr), .x_instr_i(dx_instr), .m_instr_i(xm_instr), .w_instr_i(w_instr),
        .redirect_i(redirect), .stall_o(stall), .flush_o(flush),
        .fwd_a_o(fwd_a), .fwd_b_o(fwd_b), .store_fwd_o(store_fwd)
    );

    // Written from the retire port
    reg_file u_reg_file (
        .clock_i(clock_i), .rst_n_i(rst_n_i), .ra_i(ra), .rb_i(rb),
        .rdata_a_o(rdata_a), .rdata_b_o(rdata_b),
        .we_i(wb_en_o), .wa_i(wb_reg_o), .wdata_i(wb_data_o)
    );

endmodule

/* testbench/processor_chk.sv */
// Concurrent checks bound into the core
// Reads the internal stall net of the processor
`timescale 1ns/1ps
module processor_chk (
    input logic        clock_i,
    input logic        rst_n_i,
    input logic        stall_i,
    input logic [31:0] address_imem_i,
    input logic        wren_i,
    input logic        wb_en_i,
    input logic [4:0]  wb_reg_i
);

    int unsigned assert_failures = 0;

    // From the second reset edge on, all stages hold bubbles
    reset_quiet: assert property (@(posedge clock_i)
        (!rst_n_i ##1 !rst_n_i) |-> (!wren_i && !wb_en_i))
        else begin
            $error("Store or register write while reset is held");
            assert_failures++;
        end

    no_r0_write: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        wb_en_i |-> (wb_reg_i != 5'd0))
        else begin
            $error("Retire port writes register 0");
            assert_failures++;
        end

    stall_holds_pc: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        stall_i |=> $stable(address_imem_i))
        else begin
            $error("Fetch address moved during a load-use stall");
            assert_failures++;
        end

endmodule

bind processor processor_chk u_processor_chk (
    .clock_i(clock_i), .rst_n_i(rst_n_i), .stall_i(stall), .address_imem_i(address_imem_o),
    .wren_i(wren_o), .wb_en_i(wb_en_o), .wb_reg_i(wb_reg_o)
);

/* testbench/processor_scoreboard.sv */
// Instruction-set model of the core and in-order check of retires and stores
// The image is loaded word by word before each test; registers and dmem start at zero
`timescale 1ns/1ps
module processor_scoreboard (
    input logic        clock_i,
    input logic        rst_n_i,
    input logic [31:0] address_imem_i,
    input logic        wb_en_i,
    input logic [4:0]  wb_reg_i,
    input logic [31:0] wb_data_i,
    input logic        wren_i,
    input logic [31:0] address_dmem_i,
    input logic [31:0] data_dmem_i
);

    logic [31:0] img [256];
    logic [4:0]  exp_reg [$];
    logic [31:0] exp_wdata [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_sdata [$];
    string       test_name;
    int          wr_seen = 0;
    int          st_seen = 0;
    int          test_errors = 0;
    int          total_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic        rst_q;

    task automatic put_word(input int addr, input logic [31:0] word);
        img[addr] = word;
    endtask

    // Runs the image to its final jump and records writes and stores
    task automatic start_test(input string name);
        logic [31:0]      regs [32];
        logic [31:0]      mem [64];
        proc_pkg::instr_u ins;
        logic [31:0]      pc;
        logic [31:0]      next_pc;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      imm;
        logic [31:0]      addr;
        logic [31:0]      res;
        logic             wr;
        test_name   = name;
        wr_seen     = 0;
        st_seen     = 0;
        test_errors = 0;
        exp_reg.delete();
        exp_wdata.delete();
        exp_addr.delete();
        exp_sdata.delete();
        for (int k = 0; k < 32; k++) begin
            regs[k] = '0;
        end
        for (int k = 0; k < 64; k++) begin
            mem[k] = '0;
        end
        pc = '0;
        for (int step = 0; step < 1000; step++) begin
            ins = img[pc[7:0]];
            if (ins.j.opcode == proc_pkg::OP_J && ins.j.target == pc[26:0]) break;
            a       = regs[ins.i.rs];
            b       = regs[ins.i.rd];          // Branch and store source
            imm     = {{15{ins.i.imm[16]}}, ins.i.imm};
            addr    = a + imm;
            next_pc = pc + 1;
            wr      = 1'b0;
            res     = '0;
            case (ins.r.opcode)
                proc_pkg::OP_RTYPE: begin
                    wr = 1'b1;
                    case (ins.r.alu_op)
                        proc_pkg::ALU_ADD: res = a + regs[ins.r.rt];
                        proc_pkg::ALU_SUB: res = a - regs[ins.r.rt];
                        proc_pkg::ALU_AND: res = a & regs[ins.r.rt];
                        proc_pkg::ALU_OR:  res = a | regs[ins.r.rt];
                        proc_pkg::ALU_SLL: res = a << ins.r.shamt;
                        default:           res = $signed(a) >>> ins.r.shamt;
                    endcase
                end
                proc_pkg::OP_ADDI: begin
                    wr  = 1'b1;
                    res = addr;
                end
                proc_pkg::OP_LW: begin
                    wr  = 1'b1;
                    res = mem[addr[5:0]];
                end
                proc_pkg::OP_SW: begin
                    mem[addr[5:0]] = b;
                    exp_addr.push_back(addr);
                    exp_sdata.push_back(b);
                end
                proc_pkg::OP_BNE: if (b != a) next_pc = pc + 1 + imm;
                proc_pkg::OP_BLT: if ($signed(b) < $signed(a)) next_pc = pc + 1 + imm;
                proc_pkg::OP_J:   next_pc = {5'b0, ins.j.target};
                default: ;
            endcase
            if (wr && ins.i.rd != 0) begin
                regs[ins.i.rd] = res;
                exp_reg.push_back(ins.i.rd);
                exp_wdata.push_back(res);
            end
            pc = next_pc;
        end
    endtask

    function automatic bit test_done();
        return wr_seen >= exp_reg.size() && st_seen >= exp_addr.size();
    endfunction

    always @(posedge clock_i) begin
        rst_q <= rst_n_i;
        if (rst_n_i && rst_q === 1'b0 && address_imem_i !== 32'h0) begin
            $display("FAILED %s: fetch address after reset expected 0 actual %0h",
                     test_name, address_imem_i);
            test_errors++;
        end
        if (rst_n_i && wb_en_i) begin
            if (wr_seen >= exp_reg.size()) begin
                $display("%s: register write to r%0d that the model never makes",
                         test_name, wb_reg_i);
                test_errors++;
            end else if (wb_reg_i !== exp_reg[wr_seen] || wb_data_i !== exp_wdata[wr_seen]) begin
                $display("FAILED %s: write %0d expected r%0d=%08h actual r%0d=%08h", test_name,
                         wr_seen, exp_reg[wr_seen], exp_wdata[wr_seen], wb_reg_i, wb_data_i);
                test_errors++;
            end
            wr_seen++;
        end
        if (rst_n_i && wren_i) begin
            if (st_seen >= exp_addr.size()) begin
                $display("%s: store to address %0d that the model never makes",
                         test_name, address_dmem_i);
                test_errors++;
            end else if (address_dmem_i !== exp_addr[st_seen]
                         || data_dmem_i !== exp_sdata[st_seen]) begin
                $display("FAILED %s: store %0d expected [%0d]=%08h actual [%0d]=%08h", test_name,
                         st_seen, exp_addr[st_seen], exp_sdata[st_seen], address_dmem_i,
                         data_dmem_i);
                test_errors++;
            end
            st_seen++;
        end
    end

    task automatic finish_test();
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("PASS %s: %0d writes, %0d stores", test_name, wr_seen, st_seen);
        end else begin
            tests_failed++;
            $display("FAIL %s: %0d errors", test_name, test_errors);
        end
    endtask

    task automatic report_counts(input int unsigned assert_fails);
        $display("Tests: %0d run, %0d failed, %0d check errors, %0d assertion failures",
                 tests_run, tests_failed, total_errors, assert_fails);
    endtask

endmodule

/* testbench/processor_tb.sv */
// Testbench for the five-stage core, random programs from a fixed seed
// Memories answer in the same cycle: imem 256 words, dmem 64 words
// Programs only branch forward and end in a jump to itself
`timescale 1ns/1ps
module processor_tb;

    localparam int LEN_RESET   = 6;
    localparam int LEN_ALU     = 24;
    localparam int LEN_MEM     = 24;
    localparam int LEN_BR      = 24;
    localparam int LEN_LONG    = 150;
    localparam int TOTAL       = LEN_RESET + LEN_ALU + LEN_MEM + LEN_BR + LEN_LONG + 5;
    localparam int CYCLE_LIMIT = 4 * TOTAL + 100;

    logic        clock;
    logic        rst_n;
    logic [31:0] imem [256];
    logic [31:0] dmem [64];
    logic [31:0] address_imem;
    logic [31:0] q_imem;
    logic [31:0] address_dmem;
    logic [31:0] data_dmem;
    logic [31:0] q_dmem;
    logic        wren;
    logic        wb_en;
    logic [4:0]  wb_reg;
    logic [31:0] wb_data;
    int          cycles;

    assign q_imem = imem[address_imem[7:0]];
    assign q_dmem = dmem[address_dmem[5:0]];

    processor u_processor (
        .clock_i(clock), .rst_n_i(rst_n), .address_imem_o(address_imem), .q_imem_i(q_imem),
        .address_dmem_o(address_dmem), .data_dmem_o(data_dmem), .wren_o(wren),
        .q_dmem_i(q_dmem), .wb_en_o(wb_en), .wb_reg_o(wb_reg), .wb_data_o(wb_data)
    );

    processor_scoreboard u_scoreboard (
        .clock_i(clock), .rst_n_i(rst_n), .address_imem_i(address_imem), .wb_en_i(wb_en),
        .wb_reg_i(wb_reg), .wb_data_i(wb_data), .wren_i(wren),
        .address_dmem_i(address_dmem), .data_dmem_i(data_dmem)
    );

    always @(posedge clock) begin
        if (wren) begin
            dmem[address_dmem[5:0]] <= data_dmem;
        end
    end

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clock);
            cycles++;
        end
        $display("Run timed out after %0d cycles before all tests finished", cycles);
        $display("Regression failed");
        $finish;
    end

    // Random word for slot idx of an n-word body
    function automatic logic [31:0] make_instr(input int kind, input int idx, input int n);
        proc_pkg::instr_u ins;
        logic [39:0]      mix;
        int unsigned      pick;
        int unsigned      off;
        int unsigned      nregs;
        int unsigned      cls;
        ins   = '0;
        pick  = $urandom % 10;
        off   = 1 + $urandom % 4;
        nregs = (kind == 4) ? 8 : 5;       // Few registers, dense dependencies
        if (idx + off > n) begin
            off = n - idx;                 // Never past the final jump
        end
        // Class per pick, pick 0 in the low nibble
        // 0 addi, 1 alu, 2 lw, 3 sw, 4 bne, 5 blt, 6 j
        case (kind)
            2:       mix = 40'h3332211000;
            3:       mix = 40'h6554411000;
            4:       mix = 40'h4653221100;
            default: mix = 40'h1111110000;
        endcase
        cls       = mix[pick*4 +: 4];
        ins.i.rd  = $urandom % nregs;
        ins.i.rs  = $urandom % nregs;
        ins.i.imm = $urandom;
        case (cls)
            0: ins.i.opcode = proc_pkg::OP_ADDI;
            1: begin
                ins.r.opcode = proc_pkg::OP_RTYPE;
                ins.r.rt     = $urandom % nregs;
                ins.r.shamt  = $urandom % 32;
                ins.r.alu_op = $urandom % 6;
                ins.r.zero   = '0;
            end
            2, 3: begin
                ins.i.opcode = (cls == 2) ? proc_pkg::OP_LW : proc_pkg::OP_SW;
                ins.i.rs     = '0;         // Base r0
                ins.i.imm    = $urandom % 64;
            end
            4, 5: begin
                ins.i.opcode = (cls == 4) ? proc_pkg::OP_BNE : proc_pkg::OP_BLT;
                ins.i.imm    = off - 1;    // Lands on idx + off
            end
            default: begin
                ins.j.opcode = proc_pkg::OP_J;
                ins.j.target = idx + off;
            end
        endcase
        return ins;
    endfunction

    task automatic run_test(input string name, input int kind, input int n);
        proc_pkg::instr_u self_jump;
        @(negedge clock);
        rst_n              = 1'b0;
        self_jump          = '0;
        self_jump.j.opcode = proc_pkg::OP_J;
        self_jump.j.target = n;
        for (int a = 0; a < 256; a++) begin
            imem[a] = (a < n) ? make_instr(kind, a, n) : 32'h0;
        end
        imem[n] = self_jump;
        for (int a = 0; a < 64; a++) begin
            dmem[a] = '0;
        end
        for (int a = 0; a < 256; a++) begin
            u_scoreboard.put_word(a, imem[a]);
        end
        u_scoreboard.start_test(name);
        repeat (5) @(negedge clock);
        rst_n = 1'b1;
        while (!u_scoreboard.test_done()) begin
            @(negedge clock);
        end
        repeat (5) @(negedge clock);       // Pipeline depth, catches late extras
        u_scoreboard.finish_test();
    endtask

    initial begin
        int unsigned seed_ret;
        rst_n = 1'b0;
        for (int a = 0; a < 256; a++) begin
            imem[a] = '0;
        end
        for (int a = 0; a < 64; a++) begin
            dmem[a] = '0;
        end
        seed_ret = $urandom(22);
        run_test("reset", 0, LEN_RESET);
        run_test("alu_chain", 1, LEN_ALU);
        run_test("load_store", 2, LEN_MEM);
        run_test("branch_jump", 3, LEN_BR);
        run_test("long_random", 4, LEN_LONG);
        u_scoreboard.report_counts(u_processor.u_processor_chk.assert_failures);
        if (u_scoreboard.total_errors == 0
            && u_processor.u_processor_chk.assert_failures == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* sim.f */
rtl/proc_pkg.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/hazard_unit.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/processor.sv
testbench/processor_chk.sv
testbench/processor_scoreboard.sv
testbench/processor_tb.sv

/* Bender.yml */
package:
  name: processor

sources:
  - rtl/proc_pkg.sv
  - rtl/reg_file.sv
  - rtl/alu.sv
  - rtl/hazard_unit.sv
  - rtl/fetch_stage.sv
  - rtl/decode_stage.sv
  - rtl/execute_stage.sv
  - rtl/mem_wb_stage.sv
  - rtl/processor.sv
  - target: test
    files:
      - testbench/processor_chk.sv
      - testbench/processor_scoreboard.sv
      - testbench/processor_tb.sv
